/* compile.f */
+incdir+verif
source/controlPkg.sv
source/instructionDecoder.sv
source/stateSequencer.sv
source/controlWordTable.sv
source/controlUnit.sv
verif/controlUnitTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module controlUnitTb -o controlUnitSim
./obj_dir/controlUnitSim

/* source/controlPkg.sv */
package controlPkg;

	localparam int opcodeWidth = 6;

	// primary opcodes
	localparam logic [opcodeWidth-1:0] opRType = 6'h00;
	localparam logic [opcodeWidth-1:0] opJ = 6'h02;
	localparam logic [opcodeWidth-1:0] opJal = 6'h03;
	localparam logic [opcodeWidth-1:0] opBeq = 6'h04;
	localparam logic [opcodeWidth-1:0] opBne = 6'h05;
	localparam logic [opcodeWidth-1:0] opLui = 6'h0f;
	localparam logic [opcodeWidth-1:0] opLw = 6'h23;
	localparam logic [opcodeWidth-1:0] opSw = 6'h2b;

	// R-type funct codes
	localparam logic [opcodeWidth-1:0] fnSll = 6'h00; // all-zero word is nop
	localparam logic [opcodeWidth-1:0] fnJr = 6'h08;
	localparam logic [opcodeWidth-1:0] fnBreak = 6'h0d;
	localparam logic [opcodeWidth-1:0] fnAdd = 6'h20;
	localparam logic [opcodeWidth-1:0] fnAddu = 6'h21;
	localparam logic [opcodeWidth-1:0] fnSub = 6'h22;
	localparam logic [opcodeWidth-1:0] fnSubu = 6'h23;
	localparam logic [opcodeWidth-1:0] fnAnd = 6'h24;
	localparam logic [opcodeWidth-1:0] fnXor = 6'h26;

	typedef enum logic [4:0] {
		Reset, MemoryRead, WaitMemoryRead, IrWrite, Decode,
		AddExec, AdduExec, SubExec, SubuExec, AndExec, XorExec,
		WriteRegAlu, Nop, Break, Beq, Bne,
		LwAddr, LwAddrHold, LwWait, LwMdrLoad, LwWriteBack,
		SwAddr, SwWrite, SwWait,
		Lui, Jump, JumpReg, JalWriteRa, Jal
	} stateType;

	// codes follow the datapath ALU
	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluXor = 3'd6
	} aluOpType;

	typedef enum logic [1:0] {pcAluResult, pcBranchTarget, pcJumpTarget, pcRegister} pcSourceType;
	typedef enum logic [1:0] {wbAluOut, wbMemData, wbUpperImm, wbReturnAddr} memToRegType;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstType;
	typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBBranchOff} aluSrcBType;

	typedef struct packed {
		logic memWrite;
		logic mdrLoad;
		logic pcWrite;
		logic pcWriteCond;
		pcSourceType pcSource;
		logic branchOnEqual;
		logic irWrite;
		logic aLoad;
		logic bLoad;
		logic regWrite;
		logic aluSrcA; // 0 pc, 1 register A
		aluSrcBType aluSrcB;
		aluOpType aluOp;
		logic aluOutLoad;
		regDstType regDst;
		memToRegType memToReg;
		logic iOrD; // 0 pc, 1 aluOut
	} controlWord;

	// nothing written, nothing loaded
	localparam controlWord idleWord = '{
		pcSource: pcAluResult,
		aluSrcB: srcBReg,
		aluOp: aluPass,
		regDst: dstRt,
		memToReg: wbAluOut,
		default: 1'b0
	};

endpackage

/* source/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit import controlPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [opcodeWidth-1:0] opcode,
	input logic [opcodeWidth-1:0] funct,
	output logic memWrite,
	output logic mdrLoad,
	output logic pcWrite,
	output logic pcWriteCond,
	output pcSourceType pcSource,
	output logic branchOnEqual,
	output logic irWrite,
	output logic aLoad,
	output logic bLoad,
	output logic regWrite,
	output logic aluSrcA,
	output aluSrcBType aluSrcB,
	output aluOpType aluOp,
	output logic aluOutLoad,
	output regDstType regDst,
	output memToRegType memToReg,
	output logic iOrD,
	output stateType state
);

	stateType dispatchState;
	controlWord ctrl;

	instructionDecoder decoder0 (
		.opcode(opcode),
		.funct(funct),
		.dispatchState(dispatchState)
	);

	stateSequencer sequencer0 (
		.clk(clk),
		.reset(reset),
		.dispatchState(dispatchState),
		.state(state)
	);

	controlWordTable table0 (
		.state(state),
		.ctrl(ctrl)
	);

	// control word onto the datapath strobes
	assign memWrite = ctrl.memWrite;
	assign mdrLoad = ctrl.mdrLoad;
	assign pcWrite = ctrl.pcWrite;
	assign pcWriteCond = ctrl.pcWriteCond;
	assign pcSource = ctrl.pcSource;
	assign branchOnEqual = ctrl.branchOnEqual;
	assign irWrite = ctrl.irWrite;
	assign aLoad = ctrl.aLoad;
	assign bLoad = ctrl.bLoad;
	assign regWrite = ctrl.regWrite;
	assign aluSrcA = ctrl.aluSrcA;
	assign aluSrcB = ctrl.aluSrcB;
	assign aluOp = ctrl.aluOp;
	assign aluOutLoad = ctrl.aluOutLoad;
	assign regDst = ctrl.regDst;
	assign memToReg = ctrl.memToReg;
	assign iOrD = ctrl.iOrD;

endmodule

/* source/controlWordTable.sv */
`timescale 1ns/100ps

module controlWordTable import controlPkg::*;
(
	input stateType state,
	output controlWord ctrl
);

	always_comb
	begin
		ctrl = idleWord;
		case (state)
			MemoryRead, WaitMemoryRead, IrWrite:
			begin
				// fetch at pc while alu computes pc + 4
				ctrl.irWrite = 1'b1;
				ctrl.aluSrcB = srcBFour;
				ctrl.aluOp = aluAdd;
				ctrl.pcWrite = (state == IrWrite);
			end
			Decode:
			begin
				ctrl.aLoad = 1'b1;
				ctrl.bLoad = 1'b1;
				ctrl.aluSrcB = srcBBranchOff; // branch target ahead of time
				ctrl.aluOp = aluAdd;
				ctrl.aluOutLoad = 1'b1;
			end
			AddExec, AdduExec, SubExec, SubuExec, AndExec, XorExec:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = srcBReg;
				ctrl.aluOutLoad = 1'b1;
				case (state)
					AddExec, AdduExec: ctrl.aluOp = aluAdd;
					SubExec, SubuExec: ctrl.aluOp = aluSub;
					AndExec: ctrl.aluOp = aluAnd;
					default: ctrl.aluOp = aluXor;
				endcase
			end
			WriteRegAlu:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRd;
				ctrl.memToReg = wbAluOut;
			end
			Beq, Bne:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = srcBReg;
				ctrl.aluOp = aluSub; // zero flag decides
				ctrl.pcWriteCond = 1'b1;
				ctrl.pcSource = pcBranchTarget;
				ctrl.branchOnEqual = (state == Beq);
			end
			LwAddr, SwAddr:
			begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = srcBImm;
				ctrl.aluOp = aluAdd;
				ctrl.aluOutLoad = 1'b1;
			end
			LwAddrHold, LwWait:
				ctrl.iOrD = 1'b1;
			LwMdrLoad:
			begin
				ctrl.iOrD = 1'b1;
				ctrl.mdrLoad = 1'b1;
			end
			LwWriteBack:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.memToReg = wbMemData;
			end
			SwWrite, SwWait:
			begin
				ctrl.iOrD = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			Lui:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.memToReg = wbUpperImm;
			end
			JalWriteRa:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRa; // r31
				ctrl.memToReg = wbReturnAddr;
			end
			Jump, Jal:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = pcJumpTarget;
			end
			JumpReg:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = pcRegister;
			end
			default: ctrl = idleWord; // Reset, Nop, Break
		endcase
	end

	// memory and register file never written in the same step
	noMemAndRegWrite: assert property (
		@(state) !(ctrl.memWrite && ctrl.regWrite)
	);

	noPcWriteAndCond: assert property (
		@(state) !(ctrl.pcWrite && ctrl.pcWriteCond)
	);

endmodule

/* source/instructionDecoder.sv */
`timescale 1ns/100ps

module instructionDecoder import controlPkg::*;
(
	input logic [opcodeWidth-1:0] opcode,
	input logic [opcodeWidth-1:0] funct,
	output stateType dispatchState
);

	stateType rTypeState;

	// funct only matters for opcode zero
	always_comb
	begin
		case (funct)
			fnAdd: rTypeState = AddExec;
			fnAddu: rTypeState = AdduExec;
			fnSub: rTypeState = SubExec;
			fnSubu: rTypeState = SubuExec;
			fnAnd: rTypeState = AndExec;
			fnXor: rTypeState = XorExec;
			fnJr: rTypeState = JumpReg;
			fnBreak: rTypeState = Break;
			fnSll: rTypeState = Nop; // shifts unsupported, zero word
			default: rTypeState = Nop;
		endcase
	end

	always_comb
	begin
		case (opcode)
			opRType: dispatchState = rTypeState;
			opBeq: dispatchState = Beq;
			opBne: dispatchState = Bne;
			opLw: dispatchState = LwAddr;
			opSw: dispatchState = SwAddr;
			opLui: dispatchState = Lui;
			opJ: dispatchState = Jump;
			opJal: dispatchState = JalWriteRa;
			default: dispatchState = Nop; // unknown opcode
		endcase
	end

endmodule

/* source/stateSequencer.sv */
`timescale 1ns/100ps

module stateSequencer import controlPkg::*;
(
	input logic clk,
	input logic reset,
	input stateType dispatchState,
	output stateType state
);

	stateType nextState;
	logic swHold;
	logic swHoldNext;

	always_comb
	begin
		nextState = MemoryRead;
		swHoldNext = 1'b0;
		case (state)
			Reset: nextState = MemoryRead;
			MemoryRead: nextState = WaitMemoryRead;
			WaitMemoryRead: nextState = IrWrite;
			IrWrite: nextState = Decode;
			Decode: nextState = dispatchState;
			AddExec, AdduExec, SubExec, SubuExec, AndExec, XorExec:
				nextState = WriteRegAlu;
			LwAddr: nextState = LwAddrHold;
			LwAddrHold: nextState = LwWait;
			LwWait: nextState = LwMdrLoad;
			LwMdrLoad: nextState = LwWriteBack;
			SwAddr:
			begin
				// address held a second cycle, as lw does
				swHoldNext = !swHold;
				nextState = swHold ? SwWrite : SwAddr;
			end
			SwWrite: nextState = SwWait;
			JalWriteRa: nextState = Jal;
			Break: nextState = Break; // only reset leaves
			default: nextState = MemoryRead;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= Reset;
			swHold <= 1'b0;
		end
		else
		begin
			state <= nextState;
			swHold <= swHoldNext;
		end
	end

	breakHolds: assert property (
		@(posedge clk) disable iff (reset)
		state == Break |=> state == Break
	);

	// sw address phase is exactly two cycles
	swAddrTwoCycles: assert property (
		@(posedge clk) disable iff (reset)
		$rose(state == SwAddr) |=> state == SwAddr ##1 state == SwWrite
	);

endmodule

/* verif/controlUnitVectors.svh */
typedef struct packed {
	logic [opcodeWidth-1:0] opcode;
	logic [opcodeWidth-1:0] funct;
	logic randomOp; // opcode drawn from the unused codes
	stateType dispatch;
	int length; // cycles from MemoryRead to the next MemoryRead
	logic checkAlu;
	aluOpType aluOp;
	int writes; // regWrite cycles
	regDstType regDst;
	memToRegType memToReg;
} vectorRow;

localparam int rowCount = 20;

// opcode, funct, randomOp, dispatch, length, checkAlu, aluOp, writes, regDst, memToReg
localparam vectorRow vectors [rowCount] = '{
	'{opRType, fnAdd, 1'b0, AddExec, 6, 1'b1, aluAdd, 1, dstRd, wbAluOut},
	'{opRType, fnAddu, 1'b0, AdduExec, 6, 1'b1, aluAdd, 1, dstRd, wbAluOut},
	'{opRType, fnSub, 1'b0, SubExec, 6, 1'b1, aluSub, 1, dstRd, wbAluOut},
	'{opRType, fnSubu, 1'b0, SubuExec, 6, 1'b1, aluSub, 1, dstRd, wbAluOut},
	'{opRType, fnAnd, 1'b0, AndExec, 6, 1'b1, aluAnd, 1, dstRd, wbAluOut},
	'{opRType, fnXor, 1'b0, XorExec, 6, 1'b1, aluXor, 1, dstRd, wbAluOut},
	'{opRType, fnSll, 1'b0, Nop, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opRType, 6'h3f, 1'b0, Nop, 5, 1'b0, aluPass, 0, dstRt, wbAluOut}, // unknown funct
	'{opBeq, 6'h00, 1'b0, Beq, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opBne, 6'h15, 1'b0, Bne, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opLw, 6'h04, 1'b0, LwAddr, 9, 1'b0, aluPass, 1, dstRt, wbMemData},
	'{opSw, 6'h08, 1'b0, SwAddr, 8, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opLui, 6'h00, 1'b0, Lui, 5, 1'b0, aluPass, 1, dstRt, wbUpperImm},
	'{opJ, 6'h2a, 1'b0, Jump, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opRType, fnJr, 1'b0, JumpReg, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opJal, 6'h11, 1'b0, JalWriteRa, 6, 1'b0, aluPass, 1, dstRa, wbReturnAddr},
	'{6'h00, 6'h00, 1'b1, Nop, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{6'h00, 6'h20, 1'b1, Nop, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{6'h00, 6'h3c, 1'b1, Nop, 5, 1'b0, aluPass, 0, dstRt, wbAluOut},
	'{opRType, fnBreak, 1'b0, Break, 0, 1'b0, aluPass, 0, dstRt, wbAluOut} // must stay last
};

/* verif/controlUnitTb.sv */
`timescale 1ns/100ps

module controlUnitTb import controlPkg::*;
();

	`include "controlUnitVectors.svh"

	localparam int driveDelay = 5;
	localparam int timeoutCycles = rowCount * 9 + 40;
	localparam logic [31:0] randomSeed = 32'ha53b17fc;

	logic clk, reset, memWrite, mdrLoad, pcWrite, pcWriteCond, branchOnEqual, irWrite;
	logic aLoad, bLoad, regWrite, aluSrcA, aluOutLoad, iOrD;
	logic [opcodeWidth-1:0] opcode, funct;
	pcSourceType pcSource;
	aluSrcBType aluSrcB;
	aluOpType aluOp;
	regDstType regDst;
	memToRegType memToReg;
	stateType state;
	int cycleCount;

	controlUnit dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkState(input stateType got, input stateType want);
		if (got !== want)
			failRun($sformatf("MISMATCH state expected 0x%0h actual 0x%0h", want, got));
	endtask

	task automatic checkAluOp(input aluOpType got, input aluOpType want);
		if (got !== want)
			failRun($sformatf("MISMATCH aluOp expected 0x%0h actual 0x%0h", want, got));
	endtask

	task automatic checkAluSrcB(input aluSrcBType got, input aluSrcBType want);
		if (got !== want)
			failRun($sformatf("MISMATCH aluSrcB expected 0x%0h actual 0x%0h", want, got));
	endtask

	task automatic checkPcSource(input pcSourceType got, input pcSourceType want);
		if (got !== want)
			failRun($sformatf("MISMATCH pcSource expected 0x%0h actual 0x%0h", want, got));
	endtask

	task automatic checkWriteBack(input regDstType dst, input memToRegType src,
		input regDstType wantDst, input memToRegType wantSrc);
		if (dst !== wantDst)
			failRun($sformatf("MISMATCH regDst expected 0x%0h actual 0x%0h", wantDst, dst));
		if (src !== wantSrc)
			failRun($sformatf("MISMATCH memToReg expected 0x%0h actual 0x%0h", wantSrc, src));
	endtask

	task automatic checkBit(input string name, input logic got, input logic want);
		if (got !== want)
			failRun($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, want, got));
	endtask

	task automatic checkNumber(input string name, input int got, input int want);
		if (got != want)
			failRun($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, want, got));
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#driveDelay;
	endtask

	function automatic logic [opcodeWidth-1:0] randomUnusedOpcode();
		logic [31:0] draw;
		logic [opcodeWidth-1:0] op;
		do
		begin
			draw = $urandom();
			op = draw[opcodeWidth-1:0];
		end
		while (op inside {opRType, opJ, opJal, opBeq, opBne, opLui, opLw, opSw});
		return op;
	endfunction

	task automatic checkQuiet(input stateType want);
		checkState(state, want);
		checkBit("memWrite", memWrite, 1'b0);
		checkBit("regWrite", regWrite, 1'b0);
		checkBit("pcWrite", pcWrite, 1'b0);
		checkBit("pcWriteCond", pcWriteCond, 1'b0);
	endtask

	task automatic runRow(input vectorRow row);
		int cycles;
		int writes;
		int memWrites;
		int mdrLoads;
		checkState(state, MemoryRead);
		opcode = row.randomOp ? randomUnusedOpcode() : row.opcode;
		funct = row.funct;
		for (int step = 0; step < 4; step++)
		begin
			// fetch chain, pc written only in IrWrite
			checkState(state, stateType'(int'(MemoryRead) + step));
			checkBit("pcWrite", pcWrite, step == 2);
			checkBit("irWrite", irWrite, step != 3);
			checkBit("iOrD", iOrD, 1'b0); // instruction address is pc
			if (step == 3)
			begin
				checkBit("aLoad", aLoad, 1'b1); // operands latched in decode
				checkBit("bLoad", bLoad, 1'b1);
			end
			else
			begin
				checkBit("aluSrcA", aluSrcA, 1'b0);
				checkAluSrcB(aluSrcB, srcBFour); // pc + 4
			end
			nextCycle();
		end
		checkState(state, row.dispatch);
		if (row.dispatch == Break)
		begin
			repeat (20)
			begin
				checkQuiet(Break);
				nextCycle();
			end
			return;
		end
		if (row.checkAlu)
		begin
			checkAluOp(aluOp, row.aluOp);
			checkBit("aluSrcA", aluSrcA, 1'b1); // register A against register B
			checkAluSrcB(aluSrcB, srcBReg);
			checkBit("aluOutLoad", aluOutLoad, 1'b1);
		end
		cycles = 4;
		writes = 0;
		memWrites = 0;
		mdrLoads = 0;
		while (state != MemoryRead)
		begin
			cycles++;
			if (cycles > row.length)
				failRun($sformatf("instruction ran past %0d cycles in state %s", row.length,
					state.name()));
			checkBit("pcWrite", pcWrite, state inside {Jump, JumpReg, Jal});
			checkBit("pcWriteCond", pcWriteCond, state inside {Beq, Bne});
			if (state inside {Beq, Bne})
			begin
				checkPcSource(pcSource, pcBranchTarget);
				checkBit("branchOnEqual", branchOnEqual, row.dispatch == Beq);
			end
			if (state inside {Jump, Jal})
				checkPcSource(pcSource, pcJumpTarget);
			if (state == JumpReg)
				checkPcSource(pcSource, pcRegister);
			if (state == Jal)
				checkNumber("writes before jal jump", writes, 1); // ra first
			if (memWrite || mdrLoad)
				checkBit("iOrD", iOrD, 1'b1); // data address from aluOut
			if (regWrite)
			begin
				writes++;
				checkWriteBack(regDst, memToReg, row.regDst, row.memToReg);
				if (row.checkAlu)
					checkState(state, WriteRegAlu);
				if (row.memToReg == wbMemData)
					checkNumber("mdrLoad before write-back", mdrLoads, 1);
			end
			memWrites += int'(memWrite);
			mdrLoads += int'(mdrLoad);
			nextCycle();
		end
		checkNumber("cycles", cycles, row.length);
		checkNumber("regWrite cycles", writes, row.writes);
		checkNumber("memWrite cycles", memWrites, row.dispatch == SwAddr ? 2 : 0);
		checkNumber("mdrLoad cycles", mdrLoads, row.dispatch == LwAddr ? 1 : 0);
	endtask

	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		failRun($sformatf("timeout, no result after %0d cycles", cycleCount));
	end

	initial
	begin
		void'($urandom(randomSeed));
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		repeat (4)
		begin
			nextCycle();
			checkQuiet(Reset);
		end
		reset = 1'b0;
		checkQuiet(Reset); // still Reset until the next edge
		nextCycle();
		for (int row = 0; row < rowCount; row++)
			runRow(vectors[row]);
		$display("STATUS: PASS");
		$finish;
	end

endmodule
